// File: systolic_pkg.sv
package systolic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Array geometry and bus widths
    ////////////////////////////////////////////////////////////////////////////

    // Matrix dimension, the array is N x N processing elements
    localparam int N = 4;

    localparam int DATA_W   = 8;
    localparam int ADDR_W   = 10;
    localparam int STRIDE_W = 8;
    localparam int CNT_W    = 8;

    // Pipeline depth inside one processing element
    localparam int MAC_STAGES = 3;

    // Cycles from an address on a_addr/b_addr to its word on a_data/b_data
    localparam int MEM_LATENCY = 1;

    typedef logic [DATA_W-1:0]   elem_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [STRIDE_W-1:0] stride_t;
    typedef logic [CNT_W-1:0]    cnt_t;

    // One row or column, element 0 in the low byte
    typedef logic [N*DATA_W-1:0] vec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Run schedule, counted in clk_cnt values
    ////////////////////////////////////////////////////////////////////////////

    // The last product reaches PE(N-1,N-1) after the fetch, the skew and the
    // hops across the mesh, and then needs MAC_STAGES more cycles to land
    localparam cnt_t LATCH_COUNT = cnt_t'(3 * N - 1 + MAC_STAGES);

    // N result beats follow the latch, then one cycle for the done pulse
    localparam cnt_t DONE_COUNT = cnt_t'(LATCH_COUNT + N + 1);

endpackage

// File: mac_pe.sv
`timescale 1ns/1ps

module mac_pe (
    input  logic                clk,
    input  logic                clear,
    input  systolic_pkg::elem_t in_a,
    input  systolic_pkg::elem_t in_b,
    output systolic_pkg::elem_t out_a,
    output systolic_pkg::elem_t out_b,
    output systolic_pkg::elem_t acc
);

    systolic_pkg::elem_t a_q;
    systolic_pkg::elem_t b_q;
    systolic_pkg::elem_t prod_q;

    // Stage 1 registers the operands, stage 2 the product, stage 3 the sum.
    // All arithmetic is DATA_W wide and wraps
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            a_q    <= '0;
            b_q    <= '0;
            prod_q <= '0;
            acc    <= '0;
        end
        else
        begin
            a_q    <= in_a;
            b_q    <= in_b;
            prod_q <= a_q * b_q;
            acc    <= acc + prod_q;
        end
    end

    // The operand register doubles as the hop to the neighbouring element
    assign out_a = a_q;
    assign out_b = b_q;

endmodule

// File: pe_array.sv
`timescale 1ns/1ps

module pe_array (
    input  logic                clk,
    input  logic                reset,
    input  logic                pe_reset,
    input  systolic_pkg::elem_t a_row [systolic_pkg::N],
    input  systolic_pkg::elem_t b_col [systolic_pkg::N],
    output systolic_pkg::vec_t  c_col [systolic_pkg::N]
);

    logic pe_clear;

    // Horizontal A links, column N is the unused east edge
    systolic_pkg::elem_t a_link [systolic_pkg::N][systolic_pkg::N+1];

    // Vertical B links, row N is the unused south edge
    systolic_pkg::elem_t b_link [systolic_pkg::N+1][systolic_pkg::N];

    systolic_pkg::elem_t acc_grid [systolic_pkg::N][systolic_pkg::N];

    // A second run without pe_reset adds onto the previous sums
    assign pe_clear = reset | pe_reset;

    for (genvar i = 0; i < systolic_pkg::N; i++)
    begin : g_edge
        assign a_link[i][0] = a_row[i];
        assign b_link[0][i] = b_col[i];
    end

    // PE(i,j) sits on row i and column j, A moves east and B moves south
    for (genvar i = 0; i < systolic_pkg::N; i++)
    begin : g_row
        for (genvar j = 0; j < systolic_pkg::N; j++)
        begin : g_col
            mac_pe u_pe (
                .clk   (clk),
                .clear (pe_clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .acc   (acc_grid[i][j])
            );

            // Column-major packing, row i of column j lands in byte i
            assign c_col[j][i*systolic_pkg::DATA_W +: systolic_pkg::DATA_W] = acc_grid[i][j];
        end
    end

endmodule

// File: operand_feeder.sv
`timescale 1ns/1ps

module operand_feeder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_mat_mul,
    input  systolic_pkg::cnt_t      clk_cnt,
    input  systolic_pkg::addr_t     address_mat_a,
    input  systolic_pkg::addr_t     address_mat_b,
    input  systolic_pkg::stride_t   address_stride_a,
    input  systolic_pkg::stride_t   address_stride_b,
    input  systolic_pkg::vec_t      a_data,
    input  systolic_pkg::vec_t      b_data,
    output systolic_pkg::addr_t     a_addr,
    output systolic_pkg::addr_t     b_addr,
    output systolic_pkg::elem_t     a_row [systolic_pkg::N],
    output systolic_pkg::elem_t     b_col [systolic_pkg::N]
);

    logic                fetch_active;
    systolic_pkg::cnt_t  fetch_cnt;
    logic                fetch_valid;
    systolic_pkg::vec_t  a_word;
    systolic_pkg::vec_t  b_word;
    systolic_pkg::elem_t a_lane [systolic_pkg::N];
    systolic_pkg::elem_t b_lane [systolic_pkg::N];

    ////////////////////////////////////////////////////////////////////////////
    // Address generators for the A and B memories
    ////////////////////////////////////////////////////////////////////////////

    // Idle value is one stride below the base, so the first step lands on it
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            a_addr       <= address_mat_a - systolic_pkg::addr_t'(address_stride_a);
            b_addr       <= address_mat_b - systolic_pkg::addr_t'(address_stride_b);
            fetch_active <= 1'b0;
            fetch_cnt    <= '0;
        end
        else
        begin
            if (clk_cnt < systolic_pkg::cnt_t'(systolic_pkg::N))
            begin
                a_addr       <= a_addr + systolic_pkg::addr_t'(address_stride_a);
                b_addr       <= b_addr + systolic_pkg::addr_t'(address_stride_b);
                fetch_active <= 1'b1;
            end
            else
            begin
                fetch_active <= 1'b0;
            end

            // Counts issued reads, so words are valid once the latency has passed
            if (fetch_active)
            begin
                fetch_cnt <= fetch_cnt + 1'b1;
            end
            else
            begin
                fetch_cnt <= '0;
            end
        end
    end

    assign fetch_valid = (fetch_cnt >= systolic_pkg::cnt_t'(systolic_pkg::MEM_LATENCY));

    // Anything outside the fetch window enters the array as zero
    assign a_word = fetch_valid ? a_data : '0;
    assign b_word = fetch_valid ? b_data : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Skew delay lines, lane i is held back i cycles
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < systolic_pkg::N; i++)
    begin : g_lane
        assign a_lane[i] = a_word[i*systolic_pkg::DATA_W +: systolic_pkg::DATA_W];
        assign b_lane[i] = b_word[i*systolic_pkg::DATA_W +: systolic_pkg::DATA_W];

        if (i == 0)
        begin : g_direct
            assign a_row[i] = a_lane[i];
            assign b_col[i] = b_lane[i];
        end
        else
        begin : g_delay
            systolic_pkg::elem_t a_dly [i];
            systolic_pkg::elem_t b_dly [i];

            // Flushed at the start of every run so no stale operands leak in
            always_ff @(posedge clk)
            begin
                if (reset || !start_mat_mul || clk_cnt == '0)
                begin
                    for (int k = 0; k < i; k++)
                    begin
                        a_dly[k] <= '0;
                        b_dly[k] <= '0;
                    end
                end
                else
                begin
                    a_dly[0] <= a_lane[i];
                    b_dly[0] <= b_lane[i];
                    for (int k = 1; k < i; k++)
                    begin
                        a_dly[k] <= a_dly[k-1];
                        b_dly[k] <= b_dly[k-1];
                    end
                end
            end

            assign a_row[i] = a_dly[i-1];
            assign b_col[i] = b_dly[i-1];
        end
    end

endmodule

// File: result_drain.sv
`timescale 1ns/1ps

module result_drain (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_mat_mul,
    input  systolic_pkg::cnt_t    clk_cnt,
    input  systolic_pkg::addr_t   address_mat_c,
    input  systolic_pkg::stride_t address_stride_c,
    input  systolic_pkg::vec_t    c_col [systolic_pkg::N],
    output systolic_pkg::vec_t    c_data_out,
    output systolic_pkg::addr_t   c_addr,
    output logic                  c_data_available
);

    logic                load_en;
    systolic_pkg::cnt_t  beat_cnt;
    systolic_pkg::addr_t addr_acc;
    systolic_pkg::vec_t  col_sr [systolic_pkg::N];

    // All accumulators have settled at this count
    assign load_en = (clk_cnt == systolic_pkg::LATCH_COUNT);

    ////////////////////////////////////////////////////////////////////////////
    // Beat control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            c_data_available <= 1'b0;
            beat_cnt         <= '0;
        end
        else if (load_en)
        begin
            c_data_available <= 1'b1;
            beat_cnt         <= '0;
        end
        else if (c_data_available)
        begin
            beat_cnt <= beat_cnt + 1'b1;
            // Last column is on the bus this cycle
            if (beat_cnt == systolic_pkg::cnt_t'(systolic_pkg::N - 1))
            begin
                c_data_available <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Column shift register and address accumulator
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (load_en)
        begin
            col_sr   <= c_col;
            addr_acc <= address_mat_c;
        end
        else if (c_data_available)
        begin
            for (int k = 0; k < systolic_pkg::N - 1; k++)
            begin
                col_sr[k] <= col_sr[k+1];
            end
            addr_acc <= addr_acc + systolic_pkg::addr_t'(address_stride_c);
        end
    end

    // The bus reads zero between beats
    assign c_data_out = c_data_available ? col_sr[0] : '0;
    assign c_addr     = c_data_available ? addr_acc  : '0;

endmodule

// File: matmul_4x4_top.sv
`timescale 1ns/1ps

module matmul_4x4_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pe_reset,
    input  logic                  start_mat_mul,
    input  systolic_pkg::addr_t   address_mat_a,
    input  systolic_pkg::addr_t   address_mat_b,
    input  systolic_pkg::addr_t   address_mat_c,
    input  systolic_pkg::stride_t address_stride_a,
    input  systolic_pkg::stride_t address_stride_b,
    input  systolic_pkg::stride_t address_stride_c,
    input  systolic_pkg::vec_t    a_data,
    input  systolic_pkg::vec_t    b_data,
    output logic                  done_mat_mul,
    output systolic_pkg::addr_t   a_addr,
    output systolic_pkg::addr_t   b_addr,
    output systolic_pkg::addr_t   c_addr,
    output systolic_pkg::vec_t    c_data_out,
    output logic                  c_data_available
);

    systolic_pkg::cnt_t  clk_cnt;
    systolic_pkg::elem_t a_row [systolic_pkg::N];
    systolic_pkg::elem_t b_col [systolic_pkg::N];
    systolic_pkg::vec_t  c_col [systolic_pkg::N];

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    // Dropping start aborts the run. The count stops at its top value so a
    // long-held start cannot wrap around and replay the schedule
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            clk_cnt <= '0;
        end
        else if (clk_cnt != '1)
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Single cycle, right after the last result beat
    assign done_mat_mul = (clk_cnt == systolic_pkg::DONE_COUNT);

    ////////////////////////////////////////////////////////////////////////////
    // Feeder, array and drain
    ////////////////////////////////////////////////////////////////////////////

    operand_feeder u_feeder (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .clk_cnt          (clk_cnt),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .a_data           (a_data),
        .b_data           (b_data),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .a_row            (a_row),
        .b_col            (b_col)
    );

    pe_array u_array (
        .clk      (clk),
        .reset    (reset),
        .pe_reset (pe_reset),
        .a_row    (a_row),
        .b_col    (b_col),
        .c_col    (c_col)
    );

    result_drain u_drain (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .clk_cnt          (clk_cnt),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .c_col            (c_col),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 4 ns clock period
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // Reset covers three rising edges and drops just after the third one
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: matmul_props.sv
`timescale 1ns/1ps

module matmul_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  c_data_available,
    input logic                  done_mat_mul,
    input systolic_pkg::addr_t   c_addr,
    input systolic_pkg::stride_t address_stride_c
);

    // Number of result beats already seen in the current stretch
    systolic_pkg::cnt_t beat_run;

    always_ff @(posedge clk)
    begin
        if (reset || !c_data_available)
            beat_run <= '0;
        else
            beat_run <= beat_run + 1'b1;
    end

    beats_bounded: assert property (@(posedge clk) disable iff (reset)
        c_data_available |-> beat_run < systolic_pkg::cnt_t'(systolic_pkg::N))
        else $error("c_data_available stayed high for more than N cycles");

    done_single: assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul)
        else $error("done_mat_mul lasted more than one cycle");

    addr_step: assert property (@(posedge clk) disable iff (reset)
        (c_data_available && $past(c_data_available)) |->
            c_addr == $past(c_addr) + systolic_pkg::addr_t'(address_stride_c))
        else $error("c_addr did not advance by address_stride_c between beats");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!c_data_available && !done_mat_mul))
        else $error("result strobes active during reset");

endmodule

bind matmul_4x4_top matmul_props u_props (
    .clk              (clk),
    .reset            (reset),
    .c_data_available (c_data_available),
    .done_mat_mul     (done_mat_mul),
    .c_addr           (c_addr),
    .address_stride_c (address_stride_c)
);

// File: matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb;

    localparam int NUM_ENTRIES   = 5;
    localparam int MEM_DEPTH     = 1 << systolic_pkg::ADDR_W;
    localparam int RUN_TIMEOUT   = 64;
    localparam int RESET_TIMEOUT = 16;
    localparam int DW            = systolic_pkg::DATA_W;
    localparam int MAT_W         = systolic_pkg::N * systolic_pkg::N * DW;

    // Element (i,j) of a matrix sits in byte i*N+j
    typedef logic [MAT_W-1:0] mat_t;

    logic                  clk;
    logic                  reset;
    logic                  pe_reset;
    logic                  start_mat_mul;
    systolic_pkg::addr_t   address_mat_a;
    systolic_pkg::addr_t   address_mat_b;
    systolic_pkg::addr_t   address_mat_c;
    systolic_pkg::stride_t address_stride_a;
    systolic_pkg::stride_t address_stride_b;
    systolic_pkg::stride_t address_stride_c;
    systolic_pkg::vec_t    a_data;
    systolic_pkg::vec_t    b_data;
    logic                  done_mat_mul;
    systolic_pkg::addr_t   a_addr;
    systolic_pkg::addr_t   b_addr;
    systolic_pkg::addr_t   c_addr;
    systolic_pkg::vec_t    c_data_out;
    logic                  c_data_available;

    systolic_pkg::vec_t    mem_a [MEM_DEPTH];
    systolic_pkg::vec_t    mem_b [MEM_DEPTH];
    systolic_pkg::addr_t   a_pend;
    systolic_pkg::addr_t   b_pend;
    integer                seed;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table, entry 1 gets random matrices at start-up
    ////////////////////////////////////////////////////////////////////////////

    mat_t tbl_a [NUM_ENTRIES] = '{
        128'h100f0e0d_0c0b0a09_08070605_04030201,
        128'h0,
        128'hf1e2d3c4_b5a69788_796a5b4c_3d2e1f10,
        128'h01020304_05060708_090a0b0c_0d0e0f10,
        128'hffffffff_ffffffff_ffffffff_ffffffff
    };
    mat_t tbl_b [NUM_ENTRIES] = '{
        128'h01000000_00010000_00000100_00000001,
        128'h0,
        128'h8899aabb_ccddeeff_11223344_55667788,
        128'h02000000_00020000_00000200_00000002,
        128'hffffffff_ffffffff_ffffffff_ffffffff
    };
    systolic_pkg::addr_t   tbl_base_a [NUM_ENTRIES]   = '{16, 300, 1000, 64, 900};
    systolic_pkg::stride_t tbl_stride_a [NUM_ENTRIES] = '{1, 7, 255, 2, 3};
    systolic_pkg::addr_t   tbl_base_b [NUM_ENTRIES]   = '{512, 40, 3, 128, 777};
    systolic_pkg::stride_t tbl_stride_b [NUM_ENTRIES] = '{4, 13, 200, 32, 9};
    systolic_pkg::addr_t   tbl_base_c [NUM_ENTRIES]   = '{100, 700, 1020, 0, 512};
    systolic_pkg::stride_t tbl_stride_c [NUM_ENTRIES] = '{8, 5, 3, 16, 1};
    // Entry 3 runs without pe_reset and lands on top of entry 2
    logic                  tbl_clear [NUM_ENTRIES]    = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    mat_t                  tbl_exp [NUM_ENTRIES];

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    matmul_4x4_top DUT (
        .clk              (clk),
        .reset            (reset),
        .pe_reset         (pe_reset),
        .start_mat_mul    (start_mat_mul),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_mat_c    (address_mat_c),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .address_stride_c (address_stride_c),
        .a_data           (a_data),
        .b_data           (b_data),
        .done_mat_mul     (done_mat_mul),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available)
    );

    // Memory model, the word for an address comes back one cycle later
    initial
    begin
        a_data = '0;
        b_data = '0;
        forever
        begin
            @(negedge clk);
            a_pend = a_addr;
            b_pend = b_addr;
            @(posedge clk);
            #1;
            a_data = mem_a[a_pend];
            b_data = mem_b[b_pend];
        end
    end

    function automatic systolic_pkg::elem_t get_elem(mat_t m, int i, int j);
        return m[(i*systolic_pkg::N + j)*DW +: DW];
    endfunction

    // Row k when row is set, otherwise column k, with element 0 in the low byte
    function automatic systolic_pkg::vec_t pack_word(mat_t m, int k, logic row);
        systolic_pkg::vec_t w;
        for (int x = 0; x < systolic_pkg::N; x++)
            w[x*DW +: DW] = row ? get_elem(m, k, x) : get_elem(m, x, k);
        return w;
    endfunction

    // All sums stay DATA_W wide, so they wrap modulo 256
    function automatic mat_t multiply_mod(mat_t a, mat_t b);
        mat_t                c;
        systolic_pkg::elem_t sum;
        for (int i = 0; i < systolic_pkg::N; i++)
        begin
            for (int j = 0; j < systolic_pkg::N; j++)
            begin
                sum = '0;
                for (int k = 0; k < systolic_pkg::N; k++)
                    sum = sum + get_elem(a, i, k) * get_elem(b, k, j);
                c[(i*systolic_pkg::N + j)*DW +: DW] = sum;
            end
        end
        return c;
    endfunction

    function automatic systolic_pkg::addr_t step_addr(systolic_pkg::addr_t base,
                                                      systolic_pkg::stride_t stride, int k);
        return base + systolic_pkg::addr_t'(k) * systolic_pkg::addr_t'(stride);
    endfunction

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic run_entry(input int e);
        systolic_pkg::vec_t  beat_data [$];
        systolic_pkg::addr_t beat_addr [$];
        systolic_pkg::addr_t a_seen [$];
        systolic_pkg::addr_t b_seen [$];
        int                  cycles;

        @(posedge clk);
        #1;
        // A words are columns of A, B words are rows of B
        for (int k = 0; k < systolic_pkg::N; k++)
        begin
            mem_a[step_addr(tbl_base_a[e], tbl_stride_a[e], k)] = pack_word(tbl_a[e], k, 1'b0);
            mem_b[step_addr(tbl_base_b[e], tbl_stride_b[e], k)] = pack_word(tbl_b[e], k, 1'b1);
        end
        address_mat_a    = tbl_base_a[e];
        address_mat_b    = tbl_base_b[e];
        address_mat_c    = tbl_base_c[e];
        address_stride_a = tbl_stride_a[e];
        address_stride_b = tbl_stride_b[e];
        address_stride_c = tbl_stride_c[e];
        pe_reset         = tbl_clear[e];
        @(posedge clk);
        #1;
        pe_reset      = 1'b0;
        start_mat_mul = 1'b1;

        // This falling edge still comes before t0, with the idle addresses out
        @(negedge clk);
        check_value("a_addr", 32'(a_addr), 32'(step_addr(tbl_base_a[e], tbl_stride_a[e], -1)));
        check_value("b_addr", 32'(b_addr), 32'(step_addr(tbl_base_b[e], tbl_stride_b[e], -1)));

        cycles = 0;
        while (!done_mat_mul)
        begin
            if (cycles == RUN_TIMEOUT)
            begin
                $display("Timeout: no done_mat_mul within %0d cycles of start", RUN_TIMEOUT);
                stop_run();
            end
            @(negedge clk);
            cycles++;
            if (c_data_available)
            begin
                beat_data.push_back(c_data_out);
                beat_addr.push_back(c_addr);
            end
            else
            begin
                // The result bus reads zero between beats
                check_value("c_data_out", c_data_out, 32'h0);
                check_value("c_addr", 32'(c_addr), 32'h0);
            end
            if (a_seen.size() == 0 || a_seen[$] != a_addr)
                a_seen.push_back(a_addr);
            if (b_seen.size() == 0 || b_seen[$] != b_addr)
                b_seen.push_back(b_addr);
        end

        check_value("beat count", beat_data.size(), systolic_pkg::N);
        check_value("a_addr count", a_seen.size(), systolic_pkg::N);
        check_value("b_addr count", b_seen.size(), systolic_pkg::N);
        for (int k = 0; k < systolic_pkg::N; k++)
        begin
            check_value($sformatf("c_data_out beat %0d", k), beat_data[k],
                        pack_word(tbl_exp[e], k, 1'b0));
            check_value("c_addr", 32'(beat_addr[k]),
                        32'(step_addr(tbl_base_c[e], tbl_stride_c[e], k)));
            check_value("a_addr", 32'(a_seen[k]),
                        32'(step_addr(tbl_base_a[e], tbl_stride_a[e], k)));
            check_value("b_addr", 32'(b_seen[k]),
                        32'(step_addr(tbl_base_b[e], tbl_stride_b[e], k)));
        end

        @(posedge clk);
        #1;
        start_mat_mul = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_value("c_data_available", 32'(c_data_available), 32'h0);
            check_value("done_mat_mul", 32'(done_mat_mul), 32'h0);
        end
    endtask

    initial
    begin
        mat_t        prod;
        mat_t        acc;
        logic [31:0] r;
        int          waited;

        seed             = 32'h55c02f74;
        pe_reset         = 1'b0;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;

        // Every word carries its own address, so a stray fetch spoils the product
        for (int x = 0; x < MEM_DEPTH; x++)
        begin
            mem_a[x] = {2'b10, systolic_pkg::addr_t'(x), systolic_pkg::addr_t'(x),
                        systolic_pkg::addr_t'(x)};
            mem_b[x] = {2'b01, ~systolic_pkg::addr_t'(x), systolic_pkg::addr_t'(x),
                        ~systolic_pkg::addr_t'(x)};
        end

        for (int x = 0; x < systolic_pkg::N * systolic_pkg::N; x++)
        begin
            r = $random(seed);
            tbl_a[1][x*DW +: DW] = r[DW-1:0];
            r = $random(seed);
            tbl_b[1][x*DW +: DW] = r[DW-1:0];
        end

        // Accumulators start at zero after reset
        acc = '0;
        for (int e = 0; e < NUM_ENTRIES; e++)
        begin
            prod = multiply_mod(tbl_a[e], tbl_b[e]);
            for (int x = 0; x < systolic_pkg::N * systolic_pkg::N; x++)
                acc[x*DW +: DW] = (tbl_clear[e] ? 8'h00 : acc[x*DW +: DW]) + prod[x*DW +: DW];
            tbl_exp[e] = acc;
        end

        @(negedge clk);
        waited = 0;
        while (reset)
        begin
            if (waited == RESET_TIMEOUT)
            begin
                $display("Timeout: reset was never released");
                stop_run();
            end
            @(negedge clk);
            waited++;
        end
        check_value("c_data_available", 32'(c_data_available), 32'h0);
        check_value("done_mat_mul", 32'(done_mat_mul), 32'h0);

        for (int e = 0; e < NUM_ENTRIES; e++)
            run_entry(e);

        $display("sim passed");
        $finish;
    end

endmodule

// File: vlog.f
systolic_pkg.sv
mac_pe.sv
pe_array.sv
operand_feeder.sv
result_drain.sv
matmul_4x4_top.sv
tb_clock_gen.sv
matmul_props.sv
matmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module matmul_tb -o sim_matmul &&
./obj_dir/sim_matmul | tee /dev/stderr | grep -q "sim passed" &&
echo "Simulation OK" ||
{ echo "Simulation FAILED"; exit 1; }
